// File: common/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int imem_words = 256;
	localparam int dmem_words = 256;
	// word index widths of the two memories
	localparam int imem_aw = $clog2(imem_words);
	localparam int dmem_aw = $clog2(dmem_words);

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'd0,
		op_beq   = 6'd4,
		op_addi  = 6'd8,
		op_slti  = 6'd10,
		op_lw    = 6'd35,
		op_sw    = 6'd43
	} opcode_t;

	// r-type funct, instr[5:0]
	typedef enum logic [5:0] {
		fn_sll = 6'd0,
		fn_srl = 6'd2,
		fn_add = 6'd32,
		fn_sub = 6'd34,
		fn_and = 6'd36,
		fn_or  = 6'd37,
		fn_nor = 6'd39,
		fn_slt = 6'd42
	} funct_t;

	// coarse class from control, refined by the alu
	typedef enum logic [1:0] {
		cls_add   = 2'd0, // lw, sw, addi
		cls_sub   = 2'd1, // beq compare
		cls_funct = 2'd2, // look at funct
		cls_slt   = 2'd3  // slti
	} alu_class_t;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_nor = 4'd4,
		alu_slt = 4'd5,
		alu_sll = 4'd6,
		alu_srl = 4'd7
	} alu_op_t;

endpackage

`default_nettype wire

// File: hdl/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram #(
	parameter int words = mips_pkg::imem_words
) (
	input  logic                      clk,
	input  logic                      we,
	input  logic [$clog2(words)-1:0]  addr,
	input  logic [mips_pkg::xlen-1:0] wdata,
	output logic [mips_pkg::xlen-1:0] rdata
);
	import mips_pkg::*;

	logic [xlen-1:0] mem [words];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr]; // async read

	// a write with an X address would trash an unknown word
	assert property (@(posedge clk) we |-> !$isunknown(addr))
		else $error("ram write with unknown address");

endmodule

`default_nettype wire

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         hold,
	input  logic                         pc_src,
	input  logic [mips_pkg::xlen-1:0]    branch_target,
	input  logic                         imem_we,
	input  logic [mips_pkg::imem_aw-1:0] imem_addr,
	input  logic [mips_pkg::xlen-1:0]    imem_wdata,
	output logic [mips_pkg::xlen-1:0]    id_instr,
	output logic [mips_pkg::xlen-1:0]    id_pc_next
);
	import mips_pkg::*;

	logic [xlen-1:0] pc;
	logic [xlen-1:0] pc_next;
	logic [xlen-1:0] instr;
	logic [imem_aw-1:0] imem_index;

	assign pc_next = pc + xlen'(4);

	// load port takes the single address while it writes
	assign imem_index = imem_we ? imem_addr : pc[imem_aw+1:2];

	ram #(.words(imem_words)) imem (
		.clk   (clk),
		.we    (imem_we),
		.addr  (imem_index),
		.wdata (imem_wdata),
		.rdata (instr)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc         <= '0;
			id_instr   <= '0;
			id_pc_next <= '0;
		end else if (!hold) begin
			pc         <= pc_src ? branch_target : pc_next; // taken beq from mem stage
			id_instr   <= instr;
			id_pc_next <= pc_next;
		end
	end

	// branch targets from the mem stage stay on word boundaries
	assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

endmodule

`default_nettype wire

// File: decode/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input  mips_pkg::opcode_t    opcode,
	output logic                 regdst,
	output logic                 isbranch,
	output logic                 memread,
	output logic                 memtoreg,
	output logic                 memwrite,
	output logic                 alusrc,
	output logic                 regwrite,
	output mips_pkg::alu_class_t alu_class
);
	import mips_pkg::*;

	always_comb begin
		// everything off unless the opcode turns it on
		regdst    = 1'b0;
		isbranch  = 1'b0;
		memread   = 1'b0;
		memtoreg  = 1'b0;
		memwrite  = 1'b0;
		alusrc    = 1'b0;
		regwrite  = 1'b0;
		alu_class = cls_add;
		case (opcode)
			op_rtype: begin
				regdst    = 1'b1; // dest in rd
				regwrite  = 1'b1;
				alu_class = cls_funct;
			end
			op_beq: begin
				isbranch  = 1'b1;
				alu_class = cls_sub; // zero flag decides
			end
			op_addi: begin
				alusrc   = 1'b1;
				regwrite = 1'b1;
			end
			op_slti: begin
				alusrc    = 1'b1;
				regwrite  = 1'b1;
				alu_class = cls_slt;
			end
			op_lw: begin
				alusrc   = 1'b1;
				memread  = 1'b1;
				memtoreg = 1'b1;
				regwrite = 1'b1;
			end
			op_sw: begin
				alusrc   = 1'b1;
				memwrite = 1'b1;
			end
			default: ; // unknown opcode runs as a nop
		endcase
	end

endmodule

`default_nettype wire

// File: decode/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::reg_addr_w-1:0] rreg1,
	input  logic [mips_pkg::reg_addr_w-1:0] rreg2,
	input  logic                            regwrite,
	input  logic [mips_pkg::reg_addr_w-1:0] wreg,
	input  logic [mips_pkg::xlen-1:0]       wdata,
	output logic [mips_pkg::xlen-1:0]       rdata1,
	output logic [mips_pkg::xlen-1:0]       rdata2
);
	import mips_pkg::*;

	logic [xlen-1:0] regs [2**reg_addr_w];
	logic wr_live;

	assign wr_live = regwrite && (wreg != '0); // $0 never written

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '{default: '0};
		end else if (wr_live) begin
			regs[wreg] <= wdata;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rdata1 = (rreg1 == '0) ? '0 : (wr_live && wreg == rreg1) ? wdata : regs[rreg1];
	assign rdata2 = (rreg2 == '0) ? '0 : (wr_live && wreg == rreg2) ? wdata : regs[rreg2];

	assert property (@(posedge clk) disable iff (rst) regwrite |-> !$isunknown(wdata))
		else $error("register write with unknown data");

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            hold,
	input  logic [mips_pkg::xlen-1:0]       id_instr,
	input  logic [mips_pkg::xlen-1:0]       id_pc_next,
	input  logic                            wb_regwrite,
	input  logic [mips_pkg::reg_addr_w-1:0] wb_wreg,
	input  logic [mips_pkg::xlen-1:0]       wb_wdata,
	output logic                            ex_regwrite,
	output logic                            ex_memtoreg,
	output logic                            ex_memread,
	output logic                            ex_memwrite,
	output logic                            ex_isbranch,
	output logic                            ex_regdst,
	output logic                            ex_alusrc,
	output mips_pkg::alu_class_t            ex_alu_class,
	output logic [mips_pkg::xlen-1:0]       ex_pc_next,
	output logic [mips_pkg::xlen-1:0]       ex_data_rs,
	output logic [mips_pkg::xlen-1:0]       ex_data_rt,
	output logic [mips_pkg::xlen-1:0]       ex_imm,
	output logic [mips_pkg::reg_addr_w-1:0] ex_rt,
	output logic [mips_pkg::reg_addr_w-1:0] ex_rd
);
	import mips_pkg::*;

	logic id_regwrite, id_memtoreg, id_memread, id_memwrite;
	logic id_isbranch, id_regdst, id_alusrc;
	alu_class_t id_alu_class;
	logic [xlen-1:0] id_imm;
	logic [xlen-1:0] id_data_rs;
	logic [xlen-1:0] id_data_rt;

	assign id_imm = {{(xlen-16){id_instr[15]}}, id_instr[15:0]};

	control_unit control (
		.opcode    (opcode_t'(id_instr[31:26])),
		.regdst    (id_regdst),
		.isbranch  (id_isbranch),
		.memread   (id_memread),
		.memtoreg  (id_memtoreg),
		.memwrite  (id_memwrite),
		.alusrc    (id_alusrc),
		.regwrite  (id_regwrite),
		.alu_class (id_alu_class)
	);

	regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rreg1    (id_instr[25:21]), // rs
		.rreg2    (id_instr[20:16]), // rt
		.regwrite (wb_regwrite),
		.wreg     (wb_wreg),
		.wdata    (wb_wdata),
		.rdata1   (id_data_rs),
		.rdata2   (id_data_rt)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_regwrite  <= 1'b0;
			ex_memtoreg  <= 1'b0;
			ex_memread   <= 1'b0;
			ex_memwrite  <= 1'b0;
			ex_isbranch  <= 1'b0;
			ex_regdst    <= 1'b0;
			ex_alusrc    <= 1'b0;
			ex_alu_class <= cls_add;
			ex_pc_next   <= '0;
			ex_data_rs   <= '0;
			ex_data_rt   <= '0;
			ex_imm       <= '0;
			ex_rt        <= '0;
			ex_rd        <= '0;
		end else if (!hold) begin
			ex_regwrite  <= id_regwrite;
			ex_memtoreg  <= id_memtoreg;
			ex_memread   <= id_memread;
			ex_memwrite  <= id_memwrite;
			ex_isbranch  <= id_isbranch;
			ex_regdst    <= id_regdst;
			ex_alusrc    <= id_alusrc;
			ex_alu_class <= id_alu_class;
			ex_pc_next   <= id_pc_next;
			ex_data_rs   <= id_data_rs;
			ex_data_rt   <= id_data_rt;
			ex_imm       <= id_imm; // funct and shamt ride along in here
			ex_rt        <= id_instr[20:16];
			ex_rd        <= id_instr[15:11];
		end
	end

endmodule

`default_nettype wire

// File: execute/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  mips_pkg::alu_class_t      alu_class,
	input  logic [5:0]                funct,
	input  logic [4:0]                shamt,
	input  logic [mips_pkg::xlen-1:0] s,
	input  logic [mips_pkg::xlen-1:0] t,
	output logic                      zero,
	output logic [mips_pkg::xlen-1:0] result
);
	import mips_pkg::*;

	alu_op_t op;
	logic fn_known;

	// refine the control class into an operation
	always_comb begin
		op       = alu_add;
		fn_known = 1'b1;
		case (alu_class)
			cls_add: op = alu_add;
			cls_sub: op = alu_sub;
			cls_slt: op = alu_slt;
			cls_funct: begin
				case (funct)
					fn_add: op = alu_add;
					fn_sub: op = alu_sub;
					fn_and: op = alu_and;
					fn_or:  op = alu_or;
					fn_nor: op = alu_nor;
					fn_slt: op = alu_slt;
					fn_sll: op = alu_sll;
					fn_srl: op = alu_srl;
					default: fn_known = 1'b0;
				endcase
			end
			default: op = alu_add;
		endcase
	end

	always_comb begin
		case (op)
			alu_add: result = s + t; // wraps
			alu_sub: result = s - t;
			alu_and: result = s & t;
			alu_or:  result = s | t;
			alu_nor: result = ~(s | t);
			alu_slt: result = {{(xlen-1){1'b0}}, $signed(s) < $signed(t)};
			alu_sll: result = t << shamt;
			alu_srl: result = t >> shamt;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

	// r-type funct must decode to a known op
	always_comb begin
		if (alu_class == cls_funct) begin
			assert final (fn_known)
				else $error("unsupported r-type funct %0d", funct);
		end
	end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            hold,
	input  logic                            ex_regwrite,
	input  logic                            ex_memtoreg,
	input  logic                            ex_memread,
	input  logic                            ex_memwrite,
	input  logic                            ex_isbranch,
	input  logic                            ex_regdst,
	input  logic                            ex_alusrc,
	input  mips_pkg::alu_class_t            ex_alu_class,
	input  logic [mips_pkg::xlen-1:0]       ex_pc_next,
	input  logic [mips_pkg::xlen-1:0]       ex_data_rs,
	input  logic [mips_pkg::xlen-1:0]       ex_data_rt,
	input  logic [mips_pkg::xlen-1:0]       ex_imm,
	input  logic [mips_pkg::reg_addr_w-1:0] ex_rt,
	input  logic [mips_pkg::reg_addr_w-1:0] ex_rd,
	output logic                            mem_regwrite,
	output logic                            mem_memtoreg,
	output logic                            mem_memread,
	output logic                            mem_memwrite,
	output logic                            mem_isbranch,
	output logic [mips_pkg::xlen-1:0]       mem_branch_target,
	output logic                            mem_zero,
	output logic [mips_pkg::xlen-1:0]       mem_alures,
	output logic [mips_pkg::xlen-1:0]       mem_data_rt,
	output logic [mips_pkg::reg_addr_w-1:0] mem_wreg
);
	import mips_pkg::*;

	logic [xlen-1:0] data_t;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] alures;
	logic [reg_addr_w-1:0] wreg;
	logic zero;

	assign data_t        = ex_alusrc ? ex_imm : ex_data_rt;
	assign branch_target = ex_pc_next + (ex_imm << 2); // word offset from pc+4
	assign wreg          = ex_regdst ? ex_rd : ex_rt;

	alu u_alu (
		.alu_class (ex_alu_class),
		.funct     (ex_imm[5:0]),
		.shamt     (ex_imm[10:6]),
		.s         (ex_data_rs),
		.t         (data_t),
		.zero      (zero),
		.result    (alures)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_regwrite      <= 1'b0;
			mem_memtoreg      <= 1'b0;
			mem_memread       <= 1'b0;
			mem_memwrite      <= 1'b0;
			mem_isbranch      <= 1'b0;
			mem_branch_target <= '0;
			mem_zero          <= 1'b0;
			mem_alures        <= '0;
			mem_data_rt       <= '0;
			mem_wreg          <= '0;
		end else if (!hold) begin
			mem_regwrite      <= ex_regwrite;
			mem_memtoreg      <= ex_memtoreg;
			mem_memread       <= ex_memread;
			mem_memwrite      <= ex_memwrite;
			mem_isbranch      <= ex_isbranch;
			mem_branch_target <= branch_target;
			mem_zero          <= zero;
			mem_alures        <= alures;
			mem_data_rt       <= ex_data_rt; // store data, not the immediate
			mem_wreg          <= wreg;
		end
	end

endmodule

`default_nettype wire

// File: hdl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            hold,
	input  logic                            mem_regwrite,
	input  logic                            mem_memtoreg,
	input  logic                            mem_memread,
	input  logic                            mem_memwrite,
	input  logic                            mem_isbranch,
	input  logic [mips_pkg::xlen-1:0]       mem_branch_target,
	input  logic                            mem_zero,
	input  logic [mips_pkg::xlen-1:0]       mem_alures,
	input  logic [mips_pkg::xlen-1:0]       mem_data_rt,
	input  logic [mips_pkg::reg_addr_w-1:0] mem_wreg,
	output logic                            pc_src,
	output logic [mips_pkg::xlen-1:0]       branch_target,
	output logic                            wb_regwrite,
	output logic [mips_pkg::reg_addr_w-1:0] wb_wreg,
	output logic [mips_pkg::xlen-1:0]       wb_wdata
);
	import mips_pkg::*;

	logic [xlen-1:0] memout;
	logic wb_we_q;
	logic wb_memtoreg;
	logic [xlen-1:0] wb_memout;
	logic [xlen-1:0] wb_alures;

	assign pc_src        = mem_isbranch & mem_zero; // taken beq
	assign branch_target = mem_branch_target;

	ram #(.words(dmem_words)) dmem (
		.clk   (clk),
		.we    (mem_memwrite & ~hold),
		.addr  (mem_alures[dmem_aw+1:2]), // byte address to word
		.wdata (mem_data_rt),
		.rdata (memout)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_we_q     <= 1'b0;
			wb_memtoreg <= 1'b0;
			wb_memout   <= '0;
			wb_alures   <= '0;
			wb_wreg     <= '0;
		end else if (!hold) begin
			wb_we_q     <= mem_regwrite;
			wb_memtoreg <= mem_memtoreg;
			wb_memout   <= mem_memread ? memout : '0;
			wb_alures   <= mem_alures;
			wb_wreg     <= mem_wreg;
		end
	end

	// frozen while held, and $0 writes never retire
	assign wb_regwrite = wb_we_q & ~hold & (wb_wreg != '0);
	assign wb_wdata    = wb_memtoreg ? wb_memout : wb_alures;

endmodule

`default_nettype wire

// File: hdl/mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pipe (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            hold,
	input  logic                            imem_we,
	input  logic [mips_pkg::imem_aw-1:0]    imem_addr,
	input  logic [mips_pkg::xlen-1:0]       imem_wdata,
	output logic                            retire_we,
	output logic [mips_pkg::reg_addr_w-1:0] retire_reg,
	output logic [mips_pkg::xlen-1:0]       retire_data
);
	import mips_pkg::*;

	logic [xlen-1:0] id_instr, id_pc_next;
	logic ex_regwrite, ex_memtoreg, ex_memread, ex_memwrite;
	logic ex_isbranch, ex_regdst, ex_alusrc;
	alu_class_t ex_alu_class;
	logic [xlen-1:0] ex_pc_next, ex_data_rs, ex_data_rt, ex_imm;
	logic [reg_addr_w-1:0] ex_rt, ex_rd;
	logic mem_regwrite, mem_memtoreg, mem_memread, mem_memwrite;
	logic mem_isbranch, mem_zero;
	logic [xlen-1:0] mem_branch_target, mem_alures, mem_data_rt;
	logic [reg_addr_w-1:0] mem_wreg;
	logic pc_src;
	logic [xlen-1:0] branch_target;
	logic wb_regwrite;
	logic [reg_addr_w-1:0] wb_wreg;
	logic [xlen-1:0] wb_wdata;

	fetch_stage u_fetch (
		.clk(clk), .rst(rst), .hold(hold),
		.pc_src(pc_src), .branch_target(branch_target),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.id_instr(id_instr), .id_pc_next(id_pc_next)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst), .hold(hold),
		.id_instr(id_instr), .id_pc_next(id_pc_next),
		.wb_regwrite(wb_regwrite), .wb_wreg(wb_wreg), .wb_wdata(wb_wdata),
		.ex_regwrite(ex_regwrite), .ex_memtoreg(ex_memtoreg), .ex_memread(ex_memread),
		.ex_memwrite(ex_memwrite), .ex_isbranch(ex_isbranch), .ex_regdst(ex_regdst),
		.ex_alusrc(ex_alusrc), .ex_alu_class(ex_alu_class), .ex_pc_next(ex_pc_next),
		.ex_data_rs(ex_data_rs), .ex_data_rt(ex_data_rt), .ex_imm(ex_imm),
		.ex_rt(ex_rt), .ex_rd(ex_rd)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst), .hold(hold),
		.ex_regwrite(ex_regwrite), .ex_memtoreg(ex_memtoreg), .ex_memread(ex_memread),
		.ex_memwrite(ex_memwrite), .ex_isbranch(ex_isbranch), .ex_regdst(ex_regdst),
		.ex_alusrc(ex_alusrc), .ex_alu_class(ex_alu_class), .ex_pc_next(ex_pc_next),
		.ex_data_rs(ex_data_rs), .ex_data_rt(ex_data_rt), .ex_imm(ex_imm),
		.ex_rt(ex_rt), .ex_rd(ex_rd),
		.mem_regwrite(mem_regwrite), .mem_memtoreg(mem_memtoreg),
		.mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_isbranch(mem_isbranch), .mem_branch_target(mem_branch_target),
		.mem_zero(mem_zero), .mem_alures(mem_alures),
		.mem_data_rt(mem_data_rt), .mem_wreg(mem_wreg)
	);

	memory_stage u_memory (
		.clk(clk), .rst(rst), .hold(hold),
		.mem_regwrite(mem_regwrite), .mem_memtoreg(mem_memtoreg),
		.mem_memread(mem_memread), .mem_memwrite(mem_memwrite),
		.mem_isbranch(mem_isbranch), .mem_branch_target(mem_branch_target),
		.mem_zero(mem_zero), .mem_alures(mem_alures),
		.mem_data_rt(mem_data_rt), .mem_wreg(mem_wreg),
		.pc_src(pc_src), .branch_target(branch_target),
		.wb_regwrite(wb_regwrite), .wb_wreg(wb_wreg), .wb_wdata(wb_wdata)
	);

	// retire port mirrors the write-back bus
	assign retire_we   = wb_regwrite;
	assign retire_reg  = wb_wreg;
	assign retire_data = wb_wdata;

endmodule

`default_nettype wire

// File: test/tb_program.svh
`ifndef tb_program_svh
`define tb_program_svh

// one call per imem word in address order
// columns are instruction, retired reg (0 for none), retired value and hold cycles before it
task automatic build_program();
	append_entry(itype(op_addi, 0, 1, 12), 1, 32'h0000_000c, 0);
	append_entry(itype(op_addi, 0, 2, -5), 2, 32'hffff_fffb, 0);
	append_entry(itype(op_addi, 0, 3, 246), 3, 32'h0000_00f6, 0);
	append_entry(itype(op_slti, 1, 5, 20), 5, 32'h0000_0001, 0);
	append_entry(rtype(fn_add, 1, 2, 4, 0), 4, 32'h0000_0007, 0);
	append_entry(rtype(fn_sub, 1, 2, 6, 0), 6, 32'h0000_0011, 0);
	append_entry(rtype(fn_and, 3, 1, 7, 0), 7, 32'h0000_0004, 0);
	append_entry(rtype(fn_or, 3, 1, 8, 0), 8, 32'h0000_00fe, 6); // freeze mid-run
	append_entry(rtype(fn_nor, 3, 1, 9, 0), 9, 32'hffff_ff01, 0);
	append_entry(rtype(fn_slt, 2, 1, 10, 0), 10, 32'h0000_0001, 0);
	append_entry(rtype(fn_slt, 1, 2, 11, 0), 11, 32'h0000_0000, 0);
	append_entry(rtype(fn_sll, 0, 1, 12, 4), 12, 32'h0000_00c0, 0);
	append_entry(rtype(fn_srl, 0, 2, 13, 28), 13, 32'h0000_000f, 0);
	append_entry(itype(op_slti, 2, 14, -3), 14, 32'h0000_0001, 0);
	append_entry(itype(op_slti, 1, 15, -1), 15, 32'h0000_0000, 0);
	append_entry(itype(op_addi, 0, 0, 99), 0, '0, 0); // dropped write to $0
	append_entry(32'h0, 0, '0, 0);
	append_entry(32'h0, 0, '0, 0);
	append_entry(rtype(fn_add, 0, 6, 16, 0), 16, 32'h0000_0011, 0);
	append_entry(itype(op_addi, 0, 17, 64), 17, 32'h0000_0040, 0);
	append_entry(itype(op_addi, 0, 18, -1234), 18, 32'hffff_fb2e, 0);
	append_entry(32'h0, 0, '0, 0);
	append_entry(32'h0, 0, '0, 0);
	append_entry(itype(op_sw, 17, 18, 8), 0, '0, 0);
	append_entry(itype(op_lw, 17, 19, 8), 19, 32'hffff_fb2e, 0);
	append_entry(itype(op_addi, 0, 20, 3), 20, 32'h0000_0003, 0);
	append_entry(itype(op_addi, 0, 21, 3), 21, 32'h0000_0003, 0);
	append_entry(itype(op_addi, 0, 22, 4), 22, 32'h0000_0004, 0);
	append_entry(32'h0, 0, '0, 0);
	append_entry(itype(op_beq, 20, 21, 5), 0, '0, 0); // taken to word 35
	append_entry(itype(op_addi, 0, 23, 1), 23, 32'h0000_0001, 4); // beq sits in mem while held
	append_entry(itype(op_addi, 0, 24, 2), 24, 32'h0000_0002, 0);
	append_entry(itype(op_addi, 0, 25, 3), 25, 32'h0000_0003, 0);
	append_entry(itype(op_addi, 0, 26, 85), 0, '0, 0); // skipped
	append_entry(itype(op_addi, 0, 27, 102), 0, '0, 0); // skipped
	append_entry(itype(op_beq, 20, 22, 4), 0, '0, 0); // not taken
	append_entry(itype(op_addi, 0, 28, 119), 28, 32'h0000_0077, 0);
	append_entry(rtype(fn_add, 23, 24, 29, 0), 29, 32'h0000_0003, 0);
	append_entry(itype(op_addi, 0, 30, -32768), 30, 32'hffff_8000, 0);
	append_entry(rtype(fn_sub, 0, 1, 31, 0), 31, 32'hffff_fff4, 0);
endtask

`endif

// File: test/tb_mips_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipe;
	import mips_pkg::*;

	logic clk;
	logic rst;
	logic hold;
	logic imem_we;
	logic [imem_aw-1:0] imem_addr;
	logic [xlen-1:0] imem_wdata;
	logic retire_we;
	logic [reg_addr_w-1:0] retire_reg;
	logic [xlen-1:0] retire_data;

	// program image and expected retirements share one index
	logic [xlen-1:0] prog_q [$];
	logic [reg_addr_w-1:0] exp_reg_q [$];
	logic [xlen-1:0] exp_data_q [$];
	int hold_q [$];

	mips_pipe u_dut (
		.clk         (clk),
		.rst         (rst),
		.hold        (hold),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.retire_we   (retire_we),
		.retire_reg  (retire_reg),
		.retire_data (retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [xlen-1:0] itype(opcode_t op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [xlen-1:0] rtype(funct_t fn, int rs, int rt, int rd, int shamt);
		return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
	endfunction

	task automatic append_entry(input logic [xlen-1:0] word, input int rd,
			input logic [xlen-1:0] value, input int hold_cycles);
		prog_q.push_back(word);
		exp_reg_q.push_back(reg_addr_w'(rd));
		exp_data_q.push_back(value);
		hold_q.push_back(hold_cycles);
	endtask

	`include "tb_program.svh"

	task automatic abort_run(input string why);
		$display("Verification failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_reg(input logic [reg_addr_w-1:0] got,
			input logic [reg_addr_w-1:0] exp, input int n);
		if (got !== exp) begin
			$display("ERR %0t retire %0d reg got %0d expected %0d", $time, n, got, exp);
			abort_run("retire register mismatch");
		end
	endtask

	task automatic check_data(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
			input int n);
		if (got !== exp) begin
			$display("ERR %0t retire %0d data got %08h expected %08h", $time, n, got, exp);
			abort_run("retire data mismatch");
		end
	endtask

	// every word gets written, so the unused tail holds nops
	task automatic load_imem();
		for (int a = 0; a < imem_words; a++) begin
			@(posedge clk);
			#1 imem_we = 1'b1;
			imem_addr  = imem_aw'(a);
			imem_wdata = (a < prog_q.size()) ? prog_q[a] : '0;
		end
		@(posedge clk);
		#1 imem_we = 1'b0;
	endtask

	task automatic wait_retire(input int n);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!retire_we && cycles < 40) begin
			@(negedge clk);
			cycles++;
		end
		if (!retire_we) begin
			$display("no retirement for entry %0d within 40 cycles", n);
			abort_run("retirement timeout");
		end
	endtask

	// freeze for n edges with no retirement allowed
	task automatic pause_pipeline(input int n);
		@(posedge clk);
		#1 hold = 1'b1;
		repeat (n) begin
			@(negedge clk);
			if (retire_we) begin
				$display("retirement seen at %0t while hold was high", $time);
				abort_run("retirement during hold");
			end
		end
		@(posedge clk);
		#1 hold = 1'b0;
	endtask

	initial begin
		int n;
		n          = 0;
		rst        = 1'b1;
		hold       = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		build_program();
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		load_imem();
		hold = 1'b0; // pipeline starts at pc 0

		for (int i = 0; i < prog_q.size(); i++) begin
			if (exp_reg_q[i] != '0) begin
				if (hold_q[i] > 0) begin
					pause_pipeline(hold_q[i]);
				end
				wait_retire(n);
				check_reg(retire_reg, exp_reg_q[i], n);
				check_data(retire_data, exp_data_q[i], n);
				n++;
			end
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mips_pipe.f
+incdir+test
common/mips_pkg.sv
hdl/ram.sv
hdl/fetch_stage.sv
decode/control_unit.sv
decode/regfile.sv
decode/decode_stage.sv
execute/alu.sv
execute/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipe.sv
test/tb_mips_pipe.sv

// File: Bender.yml
package:
  name: mips_pipe

sources:
  - common/mips_pkg.sv
  - hdl/ram.sv
  - hdl/fetch_stage.sv
  - decode/control_unit.sv
  - decode/regfile.sv
  - decode/decode_stage.sv
  - execute/alu.sv
  - execute/execute_stage.sv
  - hdl/memory_stage.sv
  - hdl/mips_pipe.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_mips_pipe.sv
